// File: Bender.yml
package:
  name: tomasulo_issue

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - rs_pkg.sv
      - rs_entry.sv
      - rs_bank.sv
      - alu_unit.sv
      - cdb_arbiter.sv
      - tomasulo_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tomasulo.sv

// File: alu_unit.sv
// Single-cycle integer ALU with registered CDB result
`include "rs_defs.svh"

module alu_unit (
    input  logic           clock,
    input  logic           reset,
    input  logic           issue_valid, // New operation this cycle
    input  rs_pkg::issue_t issue,       // Operands, function and tag
    output rs_pkg::cdb_t   alu_result   // Result beat, one cycle later
);

    logic [`XLEN-1:0]         result;   // Combinational result
    logic                     valid_q;  // Result beat valid
    logic [`ROB_TAG_BITS-1:0] tag_q;    // Result tag
    logic [`XLEN-1:0]         value_q;  // Result value

    ////////////////////////////////////////
    // Compute
    ////////////////////////////////////////

    always_comb begin
        case (issue.func)
            isa_pkg::ALU_ADD: result = issue.opa + issue.opb;
            isa_pkg::ALU_SUB: result = issue.opa - issue.opb;
            isa_pkg::ALU_AND: result = issue.opa & issue.opb;
            isa_pkg::ALU_OR:  result = issue.opa | issue.opb;
            isa_pkg::ALU_XOR: result = issue.opa ^ issue.opb;
            isa_pkg::ALU_SLL: result = issue.opa << issue.opb[4:0]; // Low five bits only
            isa_pkg::ALU_SRL: result = issue.opa >> issue.opb[4:0];
            isa_pkg::ALU_SLT: result = {{(`XLEN-1){1'b0}},
                                        $signed(issue.opa) < $signed(issue.opb)};
            default:          result = '0;
        endcase
    end

    ////////////////////////////////////////
    // Result register
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid; // No stall, every issue broadcasts
        end
    end

    always_ff @(posedge clock) begin
        tag_q   <= issue.rob_tag;
        value_q <= result;
    end

    assign alu_result = '{valid: valid_q, tag: tag_q, value: value_q};

endmodule

// File: cdb_arbiter.sv
// Fixed-priority CDB arbiter, ALU result ahead of external result
`include "rs_defs.svh"

module cdb_arbiter (
    input  logic         clock,
    input  logic         reset,
    input  rs_pkg::cdb_t alu_result, // Always wins the bus
    input  rs_pkg::cdb_t ext_result, // Valid bit is the request
    output rs_pkg::cdb_t cdb,        // Broadcast bus
    output logic         ext_grant   // External result is on the bus
);

    localparam logic [3:0] LOST_HOLD = 4'hf;          // Held in or just out of reset
    localparam logic [3:0] LOST_MAX  = LOST_HOLD - 1'b1; // Saturation of the count

    logic [3:0] lost_q; // Cycles the external request lost the bus

    ////////////////////////////////////////
    // Selection
    ////////////////////////////////////////

    assign ext_grant = ext_result.valid && !alu_result.valid && (lost_q != LOST_HOLD);

    always_comb begin
        if (alu_result.valid) begin
            cdb = alu_result;
        end else if (ext_grant) begin
            cdb = ext_result;
        end else begin
            cdb = '0; // Idle bus
        end
    end

    ////////////////////////////////////////
    // Lost-request count
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            lost_q <= LOST_HOLD; // Blocks the grant
        end else if (lost_q == LOST_HOLD || ext_grant || !ext_result.valid) begin
            lost_q <= '0;
        end else if (lost_q != LOST_MAX) begin
            lost_q <= lost_q + 1'b1; // Lost to an ALU beat
        end
    end

endmodule

// File: files.f
+incdir+.
isa_pkg.sv
rs_pkg.sv
rs_entry.sv
rs_bank.sv
alu_unit.sv
cdb_arbiter.sv
tomasulo_core.sv
tb_tomasulo.sv

// File: isa_pkg.sv
// ISA-level types: ALU function codes and dual-view operand word
`include "rs_defs.svh"

package isa_pkg;

    ////////////////////////////////////////
    // ALU functions
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, // a + b
        ALU_SUB = 3'd1, // a - b
        ALU_AND = 3'd2, // Bitwise and
        ALU_OR  = 3'd3, // Bitwise or
        ALU_XOR = 3'd4, // Bitwise xor
        ALU_SLL = 3'd5, // Shift left by b[4:0]
        ALU_SRL = 3'd6, // Logical shift right by b[4:0]
        ALU_SLT = 3'd7  // Signed less-than, 1 or 0
    } alu_func_e;

    ////////////////////////////////////////
    // Operand word
    ////////////////////////////////////////

    // Same bits read as a value when the operand is valid,
    // otherwise as the ROB tag of its producer in the low bits
    typedef union packed {
        logic [`XLEN-1:0] data; // Operand value
        struct packed {
            logic [`XLEN-`ROB_TAG_BITS-1:0] pad; // Ignored upper bits
            logic [`ROB_TAG_BITS-1:0]       tag; // Producer tag
        } producer;
    } operand_u;

endpackage

// File: rs_bank.sv
// Reservation station bank with free-entry allocation and issue select
`include "rs_defs.svh"

module rs_bank (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid, // Dispatch request
    input  rs_pkg::dispatch_t dispatch,       // Instruction to store
    input  rs_pkg::cdb_t      cdb,            // Wakeup broadcasts
    input  logic              fu_stall,       // Hold all issue
    output logic              dispatch_ready, // Some entry is free
    output logic              issue_valid,    // Issue port carries an instruction
    output rs_pkg::issue_t    issue           // Selected instruction
);

    localparam int IDX_BITS = `RS_IDX_BITS;

    logic [`RS_ENTRIES-1:0] busy;                   // Per-entry occupied
    logic [`RS_ENTRIES-1:0] ready;                  // Per-entry operands complete
    logic [`RS_ENTRIES-1:0] load;                   // One-hot load strobe
    logic [`RS_ENTRIES-1:0] grant;                  // One-hot issue grant
    rs_pkg::issue_t         entries [`RS_ENTRIES];  // Stored instructions
    logic                   found_free;             // Free entry located
    logic                   found_ready;            // Ready entry located
    logic [IDX_BITS-1:0]    issue_idx;              // Winner of issue select

    ////////////////////////////////////////
    // Entry array
    ////////////////////////////////////////

    for (genvar g = 0; g < `RS_ENTRIES; g++) begin : g_entry
        rs_entry u_entry (
            .clock       (clock),
            .reset       (reset),
            .load        (load[g]),
            .dispatch    (dispatch),
            .cdb         (cdb),
            .issue_grant (grant[g]),
            .busy        (busy[g]),
            .ready       (ready[g]),
            .entry       (entries[g])
        );
    end

    ////////////////////////////////////////
    // Allocation
    ////////////////////////////////////////

    // Lowest-indexed free entry takes the dispatch
    always_comb begin
        load       = '0;
        found_free = 1'b0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (!busy[i] && !found_free) begin
                load[i]    = dispatch_valid;
                found_free = 1'b1;
            end
        end
    end

    assign dispatch_ready = found_free; // Any entry free

    ////////////////////////////////////////
    // Issue selection
    ////////////////////////////////////////

    // Lowest-indexed ready entry wins, stall blocks the grant
    always_comb begin
        grant       = '0;
        issue_idx   = '0;
        found_ready = 1'b0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (ready[i] && !found_ready) begin
                issue_idx   = IDX_BITS'(i);
                found_ready = 1'b1;
            end
        end
        issue_valid = found_ready && !fu_stall;
        if (issue_valid) begin
            grant[issue_idx] = 1'b1; // Frees the entry at this edge
        end
    end

    assign issue = entries[issue_idx]; // Issue mux

endmodule

// File: rs_defs.svh
// Tomasulo issue stage sizing macros shared by packages and RTL
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

`define XLEN 32 // Integer data word width

// ROB tag width, tag 0 is reserved as "no producer"
`define ROB_TAG_BITS 5

////////////////////////////////////////
// Reservation station sizing
////////////////////////////////////////

`define RS_ENTRIES 4 // Entries in the bank, 2 to 16 supported

// Index width into the bank
`define RS_IDX_BITS (($clog2(`RS_ENTRIES) > 0) ? $clog2(`RS_ENTRIES) : 1)

`define NPC_BITS 32 // Next PC width carried through the entries

`endif

// File: rs_entry.sv
// Single reservation station entry with CDB operand wakeup
`include "rs_defs.svh"

module rs_entry (
    input  logic            clock,
    input  logic            reset,
    input  logic            load,        // Write dispatch into this entry
    input  rs_pkg::dispatch_t dispatch,  // Incoming instruction
    input  rs_pkg::cdb_t    cdb,         // Broadcast bus to snoop
    input  logic            issue_grant, // Entry selected for issue, frees it
    output logic            busy,        // Entry holds an instruction
    output logic            ready,       // Both operands present
    output rs_pkg::issue_t  entry        // Stored instruction for issue mux
);

    ////////////////////////////////////////
    // State
    ////////////////////////////////////////

    logic                     busy_q;              // Occupied
    logic                     opa_valid_q;         // Operand A captured
    logic                     opb_valid_q;         // Operand B captured
    logic [`ROB_TAG_BITS-1:0] opa_tag_q;           // Waiting producer of A
    logic [`ROB_TAG_BITS-1:0] opb_tag_q;           // Waiting producer of B
    rs_pkg::issue_t           entry_q;             // Payload and operand values

    logic                     load_a_hit;          // Broadcast matches A on load
    logic                     load_b_hit;          // Broadcast matches B on load
    logic                     snoop_a;             // Broadcast fills waiting A
    logic                     snoop_b;             // Broadcast fills waiting B

    // Tag view of each operand only counts when its valid bit is low
    assign load_a_hit = cdb.valid && !dispatch.opa_valid &&
                        (cdb.tag == dispatch.opa.producer.tag);
    assign load_b_hit = cdb.valid && !dispatch.opb_valid &&
                        (cdb.tag == dispatch.opb.producer.tag);

    assign snoop_a = busy_q && !opa_valid_q && cdb.valid && (cdb.tag == opa_tag_q);
    assign snoop_b = busy_q && !opb_valid_q && cdb.valid && (cdb.tag == opb_tag_q);

    ////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q      <= 1'b0;
            opa_valid_q <= 1'b0;
            opb_valid_q <= 1'b0;
        end else if (load) begin
            busy_q      <= 1'b1;
            opa_valid_q <= dispatch.opa_valid || load_a_hit; // Same-cycle wakeup
            opb_valid_q <= dispatch.opb_valid || load_b_hit;
        end else begin
            if (issue_grant) begin
                busy_q <= 1'b0; // Freed at issue
            end
            if (snoop_a) begin
                opa_valid_q <= 1'b1;
            end
            if (snoop_b) begin
                opb_valid_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Payload registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (load) begin
            entry_q.npc       <= dispatch.npc;
            entry_q.func      <= dispatch.func;
            entry_q.rd_mem    <= dispatch.rd_mem;
            entry_q.wr_mem    <= dispatch.wr_mem;
            entry_q.is_branch <= dispatch.is_branch;
            entry_q.rob_tag   <= dispatch.rob_tag;
            opa_tag_q         <= dispatch.opa.producer.tag; // Junk if valid, never compared
            opb_tag_q         <= dispatch.opb.producer.tag;
            entry_q.opa       <= load_a_hit ? cdb.value : dispatch.opa.data;
            entry_q.opb       <= load_b_hit ? cdb.value : dispatch.opb.data;
        end else begin
            if (snoop_a) begin
                entry_q.opa <= cdb.value; // Late operand A
            end
            if (snoop_b) begin
                entry_q.opb <= cdb.value; // Late operand B
            end
        end
    end

    assign busy  = busy_q;
    assign ready = busy_q && opa_valid_q && opb_valid_q;
    assign entry = entry_q;

endmodule

// File: rs_pkg.sv
// Reservation station traffic types: dispatch, issue and CDB beats
`include "rs_defs.svh"

package rs_pkg;

    ////////////////////////////////////////
    // Dispatch into the bank
    ////////////////////////////////////////

    typedef struct packed {
        logic [`NPC_BITS-1:0]     npc;       // Next PC, carried through
        isa_pkg::alu_func_e       func;      // ALU operation
        logic                     rd_mem;    // Memory read flag
        logic                     wr_mem;    // Memory write flag
        logic                     is_branch; // Branch flag
        logic [`ROB_TAG_BITS-1:0] rob_tag;   // Destination ROB tag
        isa_pkg::operand_u        opa;       // Value or producer tag
        isa_pkg::operand_u        opb;       // Value or producer tag
        logic                     opa_valid; // opa holds a value
        logic                     opb_valid; // opb holds a value
    } dispatch_t;

    ////////////////////////////////////////
    // Issue to the functional unit
    ////////////////////////////////////////

    typedef struct packed {
        logic [`NPC_BITS-1:0]     npc;       // Next PC
        isa_pkg::alu_func_e       func;      // ALU operation
        logic                     rd_mem;    // Memory read flag
        logic                     wr_mem;    // Memory write flag
        logic                     is_branch; // Branch flag
        logic [`ROB_TAG_BITS-1:0] rob_tag;   // Result tag
        logic [`XLEN-1:0]         opa;       // Operand A value
        logic [`XLEN-1:0]         opb;       // Operand B value
    } issue_t;

    // One broadcast beat on the common data bus
    typedef struct packed {
        logic                     valid; // Beat present
        logic [`ROB_TAG_BITS-1:0] tag;   // Producer tag
        logic [`XLEN-1:0]         value; // Result value
    } cdb_t;

endpackage

// File: tb_tomasulo.sv
// Self-checking testbench for the Tomasulo issue stage with a tag-indexed CDB scoreboard
`include "rs_defs.svh"

module tb_tomasulo;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NTAGS = 1 << `ROB_TAG_BITS;

    logic              clock = 1'b0;
    logic              reset;
    logic              dispatch_valid;
    rs_pkg::dispatch_t dispatch;
    logic              fu_stall;
    rs_pkg::cdb_t      ext_result;
    logic              dispatch_ready;
    logic              ext_grant;
    rs_pkg::cdb_t      cdb;

    logic [`XLEN-1:0] expected [NTAGS];   // Reference value per tag
    bit               pending [NTAGS];    // Tag owes exactly one beat
    int               disp_cycle [NTAGS]; // Cycle the dispatch was driven
    int               beat_cycle [NTAGS]; // Cycle the beat was seen
    int               beat_order [$];     // Tags in broadcast order
    int               cycle_cnt = 0;
    int unsigned      lcg_state = 28;     // Stimulus generator
    int unsigned      stall_state = 28;   // Stall generator
    bit               stall_random = 1'b0;
    int               next_tag = 1;       // Round-robin tag pointer
    int               errors = 0;
    int               test_errors = 0;
    int               tests_run = 0;
    int               tests_bad = 0;
    string            test_name = "reset";

    tomasulo_core UUT (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .fu_stall       (fu_stall),
        .ext_result     (ext_result),
        .dispatch_ready (dispatch_ready),
        .ext_grant      (ext_grant),
        .cdb            (cdb)
    );

    initial begin
        forever begin
            #50 clock = ~clock; // 100 ns period
        end
    end

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////

    function automatic int unsigned lcg_step(input int unsigned state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [`XLEN-1:0] rand_word();
        lcg_state = lcg_step(lcg_state);
        return lcg_state;
    endfunction

    function automatic isa_pkg::alu_func_e rand_func();
        return isa_pkg::alu_func_e'(3'(rand_word() >> 29)); // Top bits, best LCG quality
    endfunction

    function automatic logic [`XLEN-1:0] alu_ref(input isa_pkg::alu_func_e func,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (func)
            isa_pkg::ALU_ADD: return a + b;
            isa_pkg::ALU_SUB: return a - b;
            isa_pkg::ALU_AND: return a & b;
            isa_pkg::ALU_OR:  return a | b;
            isa_pkg::ALU_XOR: return a ^ b;
            isa_pkg::ALU_SLL: return a << b[4:0];
            isa_pkg::ALU_SRL: return a >> b[4:0];
            default:          return ($signed(a) < $signed(b)) ? 1 : 0; // Signed compare
        endcase
    endfunction

    // Next tag with no beat owed, tag 0 never handed out
    function automatic int alloc_tag();
        int t;
        t = next_tag;
        while (t == 0 || pending[t]) begin
            t = (t + 1) % NTAGS;
        end
        next_tag = (t + 1) % NTAGS;
        return t;
    endfunction

    // Half the time a still-pending tag, else 0 for a plain value
    function automatic int pick_dep();
        int start;
        int t;
        start = rand_word() % NTAGS;
        if (((rand_word() >> 16) % 2) == 0) begin
            return 0;
        end
        for (int i = 0; i < NTAGS; i++) begin
            t = (start + i) % NTAGS;
            if (t != 0 && pending[t]) begin
                return t;
            end
        end
        return 0;
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #10; // Drive point after the edge
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_bad++;
            $display("test %s: %0d error(s)", test_name, test_errors);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    // An operand given as a tag turns into its value once that tag has broadcast
    task automatic send_dispatch(input isa_pkg::alu_func_e func,
                                 input bit a_dep, input logic [`XLEN-1:0] a,
                                 input bit b_dep, input logic [`XLEN-1:0] b,
                                 input int tag);
        int               n;
        logic [`XLEN-1:0] a_val;
        logic [`XLEN-1:0] b_val;
        n = 0;
        while (dispatch_ready !== 1'b1 && n < 200) begin
            idle_cycles(1);
            n++;
        end
        if (dispatch_ready !== 1'b1) begin
            $display("ERROR %s: timeout waiting for dispatch_ready", test_name);
            note_error();
        end
        a_val = a_dep ? expected[a[`ROB_TAG_BITS-1:0]] : a;
        b_val = b_dep ? expected[b[`ROB_TAG_BITS-1:0]] : b;
        a_dep = a_dep && pending[a[`ROB_TAG_BITS-1:0]];
        b_dep = b_dep && pending[b[`ROB_TAG_BITS-1:0]];
        dispatch.npc     = rand_word();
        dispatch.func    = func;
        {dispatch.rd_mem, dispatch.wr_mem, dispatch.is_branch} = 3'(rand_word() >> 12);
        dispatch.rob_tag = tag[`ROB_TAG_BITS-1:0];
        dispatch.opa_valid = !a_dep;
        dispatch.opb_valid = !b_dep;
        dispatch.opa.data  = a_dep ? rand_word() : a_val; // Junk above a tag
        dispatch.opb.data  = b_dep ? rand_word() : b_val;
        if (a_dep) begin
            dispatch.opa.producer.tag = a[`ROB_TAG_BITS-1:0];
        end
        if (b_dep) begin
            dispatch.opb.producer.tag = b[`ROB_TAG_BITS-1:0];
        end
        expected[tag]   = alu_ref(func, a_val, b_val);
        pending[tag]    = 1'b1;
        disp_cycle[tag] = cycle_cnt;
        dispatch_valid  = 1'b1;
        idle_cycles(1);
        dispatch_valid  = 1'b0;
    endtask

    task automatic send_ext(input int tag, input logic [`XLEN-1:0] value);
        int n;
        expected[tag]    = value;
        pending[tag]     = 1'b1;
        ext_result.valid = 1'b1;
        ext_result.tag   = tag[`ROB_TAG_BITS-1:0];
        ext_result.value = value;
        n = 0;
        @(negedge clock);
        while (ext_grant !== 1'b1 && n < 200) begin
            @(negedge clock);
            n++;
        end
        if (ext_grant !== 1'b1) begin
            $display("ERROR %s: timeout waiting for ext_grant on tag %0d", test_name, tag);
            note_error();
        end else if (cdb.tag !== tag[`ROB_TAG_BITS-1:0]) begin
            $display("FAILED %s: granted beat tag expected %0d actual %0d",
                     test_name, tag, cdb.tag);
            note_error();
        end
        idle_cycles(1);
        ext_result = '0; // Dropped once granted
    endtask

    task automatic wait_tag(input int tag);
        int n;
        n = 0;
        while (pending[tag] && n < 200) begin
            idle_cycles(1);
            n++;
        end
        if (pending[tag]) begin
            $display("ERROR %s: tag %0d was never broadcast", test_name, tag);
            note_error();
            pending[tag] = 1'b0;
        end
    endtask

    task automatic wait_all();
        for (int t = 1; t < NTAGS; t++) begin
            wait_tag(t);
        end
    endtask

    ////////////////////////////////////////
    // CDB compare and random stall
    ////////////////////////////////////////

    // Bus is stable mid-cycle
    always @(negedge clock) begin
        if (cdb.valid === 1'b1) begin
            if (!pending[cdb.tag]) begin
                $display("ERROR %s: unexpected broadcast of tag %0d", test_name, cdb.tag);
                note_error();
            end else begin
                if (cdb.value !== expected[cdb.tag]) begin
                    $display("FAILED %s: tag %0d expected %h actual %h",
                             test_name, cdb.tag, expected[cdb.tag], cdb.value);
                    note_error();
                end
                pending[cdb.tag]    = 1'b0;
                beat_cycle[cdb.tag] = cycle_cnt;
                beat_order.push_back(cdb.tag);
            end
        end
    end

    always @(posedge clock) begin
        if (stall_random) begin
            #10;
            stall_state = lcg_step(stall_state);
            fu_stall = ((stall_state >> 20) % 4) == 0; // About one cycle in four
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int               t;
        int               n;
        int               a;
        int               b;
        int               tags [8];
        logic [`XLEN-1:0] v;
        reset            = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch         = '0;
        fu_stall         = 1'b0;
        ext_result       = '0;
        ext_result.valid = 1'b1; // Request held through reset
        repeat (5) @(posedge clock);
        #10;
        reset = 1'b0;

        begin_test("reset_and_alu");
        if (dispatch_ready !== 1'b1 || ext_grant !== 1'b0) begin
            $display("ERROR %s: dispatch_ready low or ext_grant high after reset", test_name);
            note_error();
        end
        ext_result = '0;
        repeat (3) begin
            @(negedge clock);
            if (cdb.valid !== 1'b0) begin
                $display("ERROR %s: bus carried a beat while idle after reset", test_name);
                note_error();
            end
            idle_cycles(1);
        end
        for (int f = 0; f < 8; f++) begin
            t = alloc_tag();
            send_dispatch(isa_pkg::alu_func_e'(f), 0, rand_word(), 0, rand_word(), t);
            wait_tag(t);
            if (beat_cycle[t] - disp_cycle[t] != 2) begin
                $display("FAILED %s: tag %0d latency expected 2 actual %0d",
                         test_name, t, beat_cycle[t] - disp_cycle[t]);
                note_error();
            end
        end
        end_test();

        begin_test("dependency_chain");
        for (int i = 0; i < 4; i++) begin
            tags[i] = alloc_tag();
        end
        send_dispatch(isa_pkg::ALU_ADD, 0, rand_word(), 0, rand_word(), tags[0]);
        send_dispatch(isa_pkg::ALU_SUB, 0, rand_word(), 1, tags[0], tags[1]);
        send_dispatch(isa_pkg::ALU_XOR, 0, rand_word(), 1, tags[0], tags[2]); // Same-cycle wakeup
        send_dispatch(isa_pkg::ALU_SLL, 1, tags[1], 1, tags[2], tags[3]);
        wait_all();
        if (beat_cycle[tags[0]] != disp_cycle[tags[2]]) begin
            $display("ERROR %s: producer beat missed the consumer dispatch cycle", test_name);
            note_error();
        end
        end_test();

        begin_test("external_wakeup");
        tags[0] = alloc_tag();
        expected[tags[0]] = rand_word();
        pending[tags[0]]  = 1'b1; // Owned by the external unit
        tags[1] = alloc_tag();
        send_dispatch(isa_pkg::ALU_ADD, 0, rand_word(), 1, tags[0], tags[1]);
        idle_cycles(4);
        if (!pending[tags[1]]) begin
            $display("ERROR %s: consumer broadcast before its external operand", test_name);
            note_error();
        end
        send_ext(tags[0], expected[tags[0]]);
        wait_tag(tags[1]);
        if (beat_cycle[tags[1]] - beat_cycle[tags[0]] != 2) begin
            $display("FAILED %s: wakeup latency expected 2 actual %0d",
                     test_name, beat_cycle[tags[1]] - beat_cycle[tags[0]]);
            note_error();
        end
        end_test();

        begin_test("back_pressure");
        fu_stall = 1'b1;
        n = beat_order.size();
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            tags[i] = alloc_tag();
            send_dispatch(rand_func(), 0, rand_word(), 0, rand_word(), tags[i]);
        end
        idle_cycles(3);
        if (dispatch_ready !== 1'b0 || beat_order.size() != n) begin
            $display("ERROR %s: full bank still ready or broadcast while stalled", test_name);
            note_error();
        end
        fu_stall = 1'b0;
        wait_all();
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (beat_order[n + i] != tags[i]) begin
                $display("FAILED %s: beat %0d tag expected %0d actual %0d",
                         test_name, i, tags[i], beat_order[n + i]);
                note_error();
            end
        end
        end_test();

        begin_test("cdb_arbitration");
        n = beat_order.size();
        for (int i = 0; i < 7; i++) begin
            tags[i] = alloc_tag();
        end
        v = rand_word();
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    send_dispatch(rand_func(), 0, rand_word(), 0, rand_word(), tags[i]);
                end
            end
            begin
                idle_cycles(3); // Request lands inside the ALU stream
                send_ext(tags[6], v);
            end
        join
        wait_all();
        if (beat_order.size() != n + 7 || beat_cycle[tags[6]] <= beat_cycle[tags[5]]) begin
            $display("ERROR %s: beat lost or external result granted over the ALU", test_name);
            note_error();
        end
        end_test();

        begin_test("random_run");
        n = beat_order.size();
        stall_random = 1'b1;
        for (int i = 0; i < 200; i++) begin
            t = alloc_tag();
            a = pick_dep();
            b = pick_dep();
            send_dispatch(rand_func(), a != 0, (a != 0) ? a : rand_word(),
                          b != 0, (b != 0) ? b : rand_word(), t);
        end
        stall_random = 1'b0;
        idle_cycles(1);
        fu_stall = 1'b0;
        wait_all();
        if (beat_order.size() != n + 200) begin
            $display("ERROR %s: %0d beats seen for 200 dispatches",
                     test_name, beat_order.size() - n);
            note_error();
        end
        end_test();

        $display("tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tomasulo_core.sv
// Tomasulo issue stage top: reservation bank, ALU and CDB arbiter
`include "rs_defs.svh"

module tomasulo_core (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid, // Dispatch request
    input  rs_pkg::dispatch_t dispatch,       // Instruction to dispatch
    input  logic              fu_stall,       // Hold issue
    input  rs_pkg::cdb_t      ext_result,     // External result request
    output logic              dispatch_ready, // Bank has a free entry
    output logic              ext_grant,      // External result broadcast
    output rs_pkg::cdb_t      cdb             // Common data bus
);

    logic           issue_valid; // Bank to ALU strobe
    rs_pkg::issue_t issue;       // Bank to ALU instruction
    rs_pkg::cdb_t   alu_result;  // ALU to arbiter beat

    rs_bank u_rs_bank (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .fu_stall       (fu_stall),
        .dispatch_ready (dispatch_ready),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    alu_unit u_alu_unit (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alu_result  (alu_result)
    );

    cdb_arbiter u_cdb_arbiter (
        .clock      (clock),
        .reset      (reset),
        .alu_result (alu_result),
        .ext_result (ext_result),
        .cdb        (cdb),
        .ext_grant  (ext_grant)
    );

endmodule
